//--- include/rob_defs.svh
`ifndef ROB_DEFS_SVH
`define ROB_DEFS_SVH

// buffer geometry
`define ROB_SIZE        16
`define ROB_IDX_W       4

// lanes per cycle
`define DISPATCH_WIDTH  2
`define COMMIT_WIDTH    2
`define WB_PORTS        2

// payload field widths
`define PREG_W          6
`define EXC_W           4

`endif

//--- hdl/rob_types_pkg.sv
`include "rob_defs.svh"

package rob_types_pkg;

    typedef logic [`ROB_IDX_W-1:0] rob_idx_t;

    // msb is the wrap bit, so head == tail can mean empty or full
    typedef logic [`ROB_IDX_W:0] rob_ptr_t;

    typedef logic [`ROB_IDX_W:0] rob_count_t;

    typedef logic [4:0] areg_t;
    typedef logic [`PREG_W-1:0] preg_t;

    typedef struct packed {
        logic  we;
        areg_t vrd;
        preg_t prd;
        preg_t old_prd;
    } rob_entry_t;

    // per-lane arrays
    typedef rob_idx_t [`DISPATCH_WIDTH-1:0] disp_idx_t;
    typedef rob_idx_t [`COMMIT_WIDTH-1:0] commit_idx_t;
    typedef rob_idx_t [`WB_PORTS-1:0] wb_idx_t;
    typedef rob_entry_t [`DISPATCH_WIDTH-1:0] disp_entry_t;
    typedef rob_entry_t [`COMMIT_WIDTH-1:0] commit_entry_t;

endpackage

//--- hdl/rob_exc_pkg.sv
`include "rob_defs.svh"

package rob_exc_pkg;

    typedef logic [`EXC_W-1:0] exc_code_t;

    // all ones marks a clean write-back
    localparam exc_code_t EXC_NONE        = '1;
    localparam exc_code_t EXC_ILLEGAL     = exc_code_t'(2);
    localparam exc_code_t EXC_LOAD_FAULT  = exc_code_t'(5);
    localparam exc_code_t EXC_STORE_FAULT = exc_code_t'(7);

    typedef exc_code_t [`WB_PORTS-1:0] wb_exc_t;
    typedef exc_code_t [`COMMIT_WIDTH-1:0] commit_exc_t;

endpackage

//--- hdl/rob_read_if.sv
`timescale 1ns/1ps
`include "rob_defs.svh"

// commit window lookup, lane i always looks at head + i
interface rob_read_if;
    import rob_types_pkg::*;
    import rob_exc_pkg::*;

    commit_idx_t              read_idx;
    commit_entry_t            entry;
    logic [`COMMIT_WIDTH-1:0] done;
    commit_exc_t              exc;

    modport ctrl (
        output read_idx,
        input  entry,
        input  done,
        input  exc
    );

    modport payload (
        input  read_idx,
        output entry
    );

    modport status (
        input  read_idx,
        output done,
        output exc
    );

endinterface

//--- hdl/rob_slot_ram.sv
`timescale 1ns/1ps

module rob_slot_ram #(
    parameter type slot_t = logic [7:0],
    parameter int  DEPTH  = 16,
    parameter int  WPORTS = 2,
    parameter int  RPORTS = 2
) (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic [WPORTS-1:0]                     we,
    input  rob_types_pkg::rob_idx_t [WPORTS-1:0]  waddr,
    input  slot_t [WPORTS-1:0]                    wdata,
    input  rob_types_pkg::rob_idx_t [RPORTS-1:0]  raddr,
    output slot_t [RPORTS-1:0]                    rdata
);

    slot_t mem [DEPTH];

    // later ports overwrite earlier ones on an address clash
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mem <= '{default: '0};
        end else begin
            for (int p = 0; p < WPORTS; p++) begin
                if (we[p]) begin
                    mem[waddr[p]] <= wdata[p];
                end
            end
        end
    end

    for (genvar r = 0; r < RPORTS; r++) begin : g_read
        assign rdata[r] = mem[raddr[r]];
    end

endmodule

//--- hdl/rob_payload_store.sv
`timescale 1ns/1ps
`include "rob_defs.svh"

module rob_payload_store (
    input  logic                             clk,
    input  logic                             rst,
    input  logic [`DISPATCH_WIDTH-1:0]       alloc_en,
    input  rob_types_pkg::disp_idx_t         alloc_idx,
    input  rob_types_pkg::disp_entry_t       dispatch_entry,
    rob_read_if.payload                      rd
);
    import rob_types_pkg::*;

    commit_entry_t rd_entry;

    rob_slot_ram #(
        .slot_t (rob_entry_t),
        .DEPTH  (`ROB_SIZE),
        .WPORTS (`DISPATCH_WIDTH),
        .RPORTS (`COMMIT_WIDTH)
    ) u_entry_ram (
        .clk   (clk),
        .rst   (rst),
        .we    (alloc_en),
        .waddr (alloc_idx),
        .wdata (dispatch_entry),
        .raddr (rd.read_idx),
        .rdata (rd_entry)
    );

    assign rd.entry = rd_entry;

endmodule

//--- hdl/rob_status_table.sv
`timescale 1ns/1ps
`include "rob_defs.svh"

module rob_status_table (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [`DISPATCH_WIDTH-1:0]  alloc_en,
    input  rob_types_pkg::disp_idx_t    alloc_idx,
    input  logic [`WB_PORTS-1:0]        wb_valid,
    input  rob_types_pkg::wb_idx_t      wb_idx,
    input  rob_exc_pkg::wb_exc_t        wb_exc,
    rob_read_if.status                  rd
);
    import rob_exc_pkg::*;

    logic [`ROB_SIZE-1:0] done_q;
    commit_exc_t          rd_exc;

    // allocation clears first so a same-cycle write-back still lands
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            done_q <= '0;
        end else begin
            for (int j = 0; j < `DISPATCH_WIDTH; j++) begin
                if (alloc_en[j]) begin
                    done_q[alloc_idx[j]] <= 1'b0;
                end
            end
            for (int p = 0; p < `WB_PORTS; p++) begin
                if (wb_valid[p]) begin
                    done_q[wb_idx[p]] <= 1'b1;
                end
            end
        end
    end

    // code is written together with done, so a stale code is never seen
    rob_slot_ram #(
        .slot_t (exc_code_t),
        .DEPTH  (`ROB_SIZE),
        .WPORTS (`WB_PORTS),
        .RPORTS (`COMMIT_WIDTH)
    ) u_exc_ram (
        .clk   (clk),
        .rst   (rst),
        .we    (wb_valid),
        .waddr (wb_idx),
        .wdata (wb_exc),
        .raddr (rd.read_idx),
        .rdata (rd_exc)
    );

    for (genvar i = 0; i < `COMMIT_WIDTH; i++) begin : g_rd
        assign rd.done[i] = done_q[rd.read_idx[i]];
    end

    assign rd.exc = rd_exc;

endmodule

//--- hdl/rob_commit_ctrl.sv
`timescale 1ns/1ps
`include "rob_defs.svh"

module rob_commit_ctrl (
    input  logic                                         clk,
    input  logic                                         rst,
    input  logic [`DISPATCH_WIDTH-1:0]                   dispatch_valid,
    output logic                                         dispatch_ready,
    output rob_types_pkg::disp_idx_t                     dispatch_idx,
    output logic [`DISPATCH_WIDTH-1:0]                   alloc_en,
    output rob_types_pkg::disp_idx_t                     alloc_idx,
    rob_read_if.ctrl                                     rd,
    output logic [`COMMIT_WIDTH-1:0]                     commit_valid,
    output logic [`COMMIT_WIDTH-1:0]                     commit_we,
    output rob_types_pkg::areg_t [`COMMIT_WIDTH-1:0]     commit_vrd,
    output rob_types_pkg::preg_t [`COMMIT_WIDTH-1:0]     commit_prd,
    output rob_types_pkg::preg_t [`COMMIT_WIDTH-1:0]     commit_old_prd,
    output logic                                         exc_valid,
    output rob_types_pkg::rob_idx_t                      exc_idx,
    output rob_exc_pkg::exc_code_t                       exc_code
);
    import rob_types_pkg::*;
    import rob_exc_pkg::*;

    rob_ptr_t   head_q;
    rob_ptr_t   tail_q;
    rob_count_t count_q;
    rob_count_t free_cnt;
    rob_count_t disp_cnt;
    rob_count_t commit_cnt;

    logic [`COMMIT_WIDTH-1:0] commit_sel;
    logic [`COMMIT_WIDTH-1:0] exc_sel;
    logic                     chain;
    logic                     cut;

    // dispatch side
    assign free_cnt       = rob_count_t'(`ROB_SIZE) - count_q;
    assign dispatch_ready = free_cnt >= rob_count_t'(`DISPATCH_WIDTH);

    for (genvar j = 0; j < `DISPATCH_WIDTH; j++) begin : g_disp
        assign dispatch_idx[j] = tail_q[`ROB_IDX_W-1:0] + rob_idx_t'(j);
        assign alloc_idx[j]    = dispatch_idx[j];
        assign alloc_en[j]     = dispatch_valid[j] & dispatch_ready;
    end

    always_comb begin
        disp_cnt = '0;
        for (int j = 0; j < `DISPATCH_WIDTH; j++) begin
            disp_cnt = disp_cnt + rob_count_t'(alloc_en[j]);
        end
    end

    // commit window starts at head
    for (genvar i = 0; i < `COMMIT_WIDTH; i++) begin : g_win
        assign rd.read_idx[i] = head_q[`ROB_IDX_W-1:0] + rob_idx_t'(i);
    end

    // an excepting lane ends the group, and the cycle after a report commits nothing
    always_comb begin
        chain      = ~exc_valid;
        cut        = 1'b0;
        commit_sel = '0;
        exc_sel    = '0;
        commit_cnt = '0;
        for (int i = 0; i < `COMMIT_WIDTH; i++) begin
            chain         = chain & rd.done[i] & (count_q > rob_count_t'(i));
            commit_sel[i] = chain & ~cut;
            exc_sel[i]    = commit_sel[i] & (rd.exc[i] != EXC_NONE);
            cut           = cut | exc_sel[i];
            commit_cnt    = commit_cnt + rob_count_t'(commit_sel[i]);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            head_q  <= head_q + commit_cnt;
            tail_q  <= tail_q + disp_cnt;
            count_q <= count_q + disp_cnt - commit_cnt;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            commit_valid <= '0;
            commit_we    <= '0;
            exc_valid    <= 1'b0;
        end else begin
            commit_valid <= commit_sel;
            for (int i = 0; i < `COMMIT_WIDTH; i++) begin
                commit_we[i] <= commit_sel[i] & rd.entry[i].we & ~exc_sel[i];
            end
            exc_valid <= |exc_sel;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `COMMIT_WIDTH; i++) begin
            commit_vrd[i]     <= rd.entry[i].vrd;
            commit_prd[i]     <= rd.entry[i].prd;
            commit_old_prd[i] <= rd.entry[i].old_prd;
            if (exc_sel[i]) begin
                exc_idx  <= rd.read_idx[i];
                exc_code <= rd.exc[i];
            end
        end
    end

endmodule

//--- hdl/rob_top.sv
`timescale 1ns/1ps
`include "rob_defs.svh"

module rob_top (
    input  logic                                         clk,
    input  logic                                         rst,
    input  logic [`DISPATCH_WIDTH-1:0]                   dispatch_valid,
    output logic                                         dispatch_ready,
    output rob_types_pkg::disp_idx_t                     dispatch_idx,
    input  logic [`DISPATCH_WIDTH-1:0]                   dispatch_we,
    input  rob_types_pkg::areg_t [`DISPATCH_WIDTH-1:0]   dispatch_vrd,
    input  rob_types_pkg::preg_t [`DISPATCH_WIDTH-1:0]   dispatch_prd,
    input  rob_types_pkg::preg_t [`DISPATCH_WIDTH-1:0]   dispatch_old_prd,
    input  logic [`WB_PORTS-1:0]                         wb_valid,
    input  rob_types_pkg::wb_idx_t                       wb_idx,
    input  rob_exc_pkg::wb_exc_t                         wb_exc,
    output logic [`COMMIT_WIDTH-1:0]                     commit_valid,
    output logic [`COMMIT_WIDTH-1:0]                     commit_we,
    output rob_types_pkg::areg_t [`COMMIT_WIDTH-1:0]     commit_vrd,
    output rob_types_pkg::preg_t [`COMMIT_WIDTH-1:0]     commit_prd,
    output rob_types_pkg::preg_t [`COMMIT_WIDTH-1:0]     commit_old_prd,
    output logic                                         exc_valid,
    output rob_types_pkg::rob_idx_t                      exc_idx,
    output rob_exc_pkg::exc_code_t                       exc_code
);
    import rob_types_pkg::*;

    logic [`DISPATCH_WIDTH-1:0] alloc_en;
    disp_idx_t                  alloc_idx;
    disp_entry_t                dispatch_entry;

    rob_read_if rd_if ();

    for (genvar j = 0; j < `DISPATCH_WIDTH; j++) begin : g_pack
        assign dispatch_entry[j].we      = dispatch_we[j];
        assign dispatch_entry[j].vrd     = dispatch_vrd[j];
        assign dispatch_entry[j].prd     = dispatch_prd[j];
        assign dispatch_entry[j].old_prd = dispatch_old_prd[j];
    end

    rob_payload_store u_payload (
        .clk            (clk),
        .rst            (rst),
        .alloc_en       (alloc_en),
        .alloc_idx      (alloc_idx),
        .dispatch_entry (dispatch_entry),
        .rd             (rd_if.payload)
    );

    rob_status_table u_status (
        .clk       (clk),
        .rst       (rst),
        .alloc_en  (alloc_en),
        .alloc_idx (alloc_idx),
        .wb_valid  (wb_valid),
        .wb_idx    (wb_idx),
        .wb_exc    (wb_exc),
        .rd        (rd_if.status)
    );

    rob_commit_ctrl u_ctrl (
        .clk            (clk),
        .rst            (rst),
        .dispatch_valid (dispatch_valid),
        .dispatch_ready (dispatch_ready),
        .dispatch_idx   (dispatch_idx),
        .alloc_en       (alloc_en),
        .alloc_idx      (alloc_idx),
        .rd             (rd_if.ctrl),
        .commit_valid   (commit_valid),
        .commit_we      (commit_we),
        .commit_vrd     (commit_vrd),
        .commit_prd     (commit_prd),
        .commit_old_prd (commit_old_prd),
        .exc_valid      (exc_valid),
        .exc_idx        (exc_idx),
        .exc_code       (exc_code)
    );

endmodule

//--- test/tb_rob_top.sv
`timescale 1ns/1ps
`include "rob_defs.svh"

module tb_rob_top;
    import rob_types_pkg::*;
    import rob_exc_pkg::*;

    typedef struct packed {
        rob_entry_t ent;
        rob_idx_t   idx;
    } model_t;

    logic                                clk;
    logic                                rst;
    logic [`DISPATCH_WIDTH-1:0]          dispatch_valid;
    logic                                dispatch_ready;
    disp_idx_t                           dispatch_idx;
    logic [`DISPATCH_WIDTH-1:0]          dispatch_we;
    areg_t [`DISPATCH_WIDTH-1:0]         dispatch_vrd;
    preg_t [`DISPATCH_WIDTH-1:0]         dispatch_prd;
    preg_t [`DISPATCH_WIDTH-1:0]         dispatch_old_prd;
    logic [`WB_PORTS-1:0]                wb_valid;
    wb_idx_t                             wb_idx;
    wb_exc_t                             wb_exc;
    logic [`COMMIT_WIDTH-1:0]            commit_valid;
    logic [`COMMIT_WIDTH-1:0]            commit_we;
    areg_t [`COMMIT_WIDTH-1:0]           commit_vrd;
    preg_t [`COMMIT_WIDTH-1:0]           commit_prd;
    preg_t [`COMMIT_WIDTH-1:0]           commit_old_prd;
    logic                                exc_valid;
    rob_idx_t                            exc_idx;
    exc_code_t                           exc_code;

    logic [31:0] lcg_state;
    model_t      model_q[$];
    int          new_slots[$];
    int          wb_q[$];
    exc_code_t   exp_exc [`ROB_SIZE];
    logic        wb_seen [`ROB_SIZE];
    int          exp_tail;
    logic        after_exc = 1'b0;
    logic        mon_exc_hit;
    model_t      mon_entry;

    rob_top UUT (
        .clk            (clk),
        .rst            (rst),
        .dispatch_valid (dispatch_valid),
        .dispatch_ready (dispatch_ready),
        .dispatch_idx   (dispatch_idx),
        .dispatch_we    (dispatch_we),
        .dispatch_vrd   (dispatch_vrd),
        .dispatch_prd   (dispatch_prd),
        .dispatch_old_prd (dispatch_old_prd),
        .wb_valid       (wb_valid),
        .wb_idx         (wb_idx),
        .wb_exc         (wb_exc),
        .commit_valid   (commit_valid),
        .commit_we      (commit_we),
        .commit_vrd     (commit_vrd),
        .commit_prd     (commit_prd),
        .commit_old_prd (commit_old_prd),
        .exc_valid      (exc_valid),
        .exc_idx        (exc_idx),
        .exc_code       (exc_code)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check_equal(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0t ns %s got 0x%0h expected 0x%0h", $time, name, got, exp);
            $display("TB FAILED");
            $fatal(1);
        end
    endtask

    task automatic report_failure(input string what);
        $display("%0t ns: %s", $time, what);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic wait_ready();
        int cycles;
        cycles = 0;
        while (dispatch_ready !== 1'b1) begin
            if (cycles >= 200) begin
                report_failure("dispatch_ready stayed low for 200 cycles");
            end
            @(negedge clk);
            cycles++;
        end
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (model_q.size() != 0) begin
            if (cycles >= 500) begin
                report_failure("dispatched entries did not all commit within 500 cycles");
            end
            @(negedge clk);
            cycles++;
        end
    endtask

    // random payloads, each accepted lane goes into the model queue
    task automatic dispatch_entries(input int n);
        int          left;
        int          lanes;
        logic [31:0] r;
        model_t      m;
        left = n;
        while (left > 0) begin
            wait_ready();
            lanes = (left >= `DISPATCH_WIDTH) ? `DISPATCH_WIDTH : left;
            for (int j = 0; j < lanes; j++) begin
                r = lcg_next();
                check_equal("dispatch_idx", dispatch_idx[j], (exp_tail + j) % `ROB_SIZE);
                dispatch_valid[j]   = 1'b1;
                dispatch_we[j]      = r[8];
                dispatch_vrd[j]     = r[13:9];
                dispatch_prd[j]     = r[19:14];
                dispatch_old_prd[j] = r[25:20];
                m.ent.we      = r[8];
                m.ent.vrd     = r[13:9];
                m.ent.prd     = r[19:14];
                m.ent.old_prd = r[25:20];
                m.idx         = rob_idx_t'((exp_tail + j) % `ROB_SIZE);
                model_q.push_back(m);
                new_slots.push_back((exp_tail + j) % `ROB_SIZE);
            end
            @(negedge clk);
            dispatch_valid = '0;
            exp_tail += lanes;
            left -= lanes;
        end
    endtask

    task automatic drive_writeback(input int n, input int s0, input exc_code_t c0,
                                   input int s1, input exc_code_t c1);
        wb_valid[0] = 1'b1;
        wb_idx[0]   = rob_idx_t'(s0);
        wb_exc[0]   = c0;
        exp_exc[s0] = c0;
        wb_seen[s0] = 1'b1;
        if (n > 1) begin
            wb_valid[1] = 1'b1;
            wb_idx[1]   = rob_idx_t'(s1);
            wb_exc[1]   = c1;
            exp_exc[s1] = c1;
            wb_seen[s1] = 1'b1;
        end
        @(negedge clk);
        wb_valid = '0;
    endtask

    // clean write-backs of wb_q, two per cycle
    task automatic flush_writebacks();
        int a;
        int b;
        while (wb_q.size() >= 2) begin
            a = wb_q.pop_front();
            b = wb_q.pop_front();
            drive_writeback(2, a, EXC_NONE, b, EXC_NONE);
        end
        if (wb_q.size() == 1) begin
            a = wb_q.pop_front();
            drive_writeback(1, a, EXC_NONE, 0, EXC_NONE);
        end
    endtask

    // commit monitor, compares each retirement with the oldest model entry
    always @(negedge clk) begin
        if (!rst) begin
            if (after_exc) begin
                check_equal("commit_valid after exception", commit_valid, 0);
            end
            if (commit_valid[0] !== 1'b1 && commit_valid[1] === 1'b1) begin
                report_failure("commit lane 1 valid without lane 0");
            end
            mon_exc_hit = 1'b0;
            for (int i = 0; i < `COMMIT_WIDTH; i++) begin
                if (commit_valid[i] === 1'b1) begin
                    if (mon_exc_hit) begin
                        report_failure("an entry committed past an excepting entry");
                    end
                    if (model_q.size() == 0) begin
                        report_failure("a commit appeared with no dispatched entry left");
                    end
                    mon_entry = model_q.pop_front();
                    if (wb_seen[mon_entry.idx] !== 1'b1) begin
                        report_failure("an entry committed before it was written back");
                    end
                    wb_seen[mon_entry.idx] = 1'b0;
                    check_equal("commit_vrd", commit_vrd[i], mon_entry.ent.vrd);
                    check_equal("commit_prd", commit_prd[i], mon_entry.ent.prd);
                    check_equal("commit_old_prd", commit_old_prd[i], mon_entry.ent.old_prd);
                    if (exp_exc[mon_entry.idx] != EXC_NONE) begin
                        check_equal("commit_we", commit_we[i], 0);
                        check_equal("exc_valid", exc_valid, 1);
                        check_equal("exc_idx", exc_idx, mon_entry.idx);
                        check_equal("exc_code", exc_code, exp_exc[mon_entry.idx]);
                        mon_exc_hit = 1'b1;
                    end else begin
                        check_equal("commit_we", commit_we[i], mon_entry.ent.we);
                    end
                end
            end
            if (exc_valid === 1'b1 && !mon_exc_hit) begin
                report_failure("exc_valid rose without an excepting commit");
            end
            after_exc = exc_valid;
        end
    end

    task automatic reset_values();
        check_equal("dispatch_ready", dispatch_ready, 1);
        check_equal("commit_valid", commit_valid, 0);
        check_equal("exc_valid", exc_valid, 0);
        check_equal("dispatch_idx[0]", dispatch_idx[0], 0);
        check_equal("dispatch_idx[1]", dispatch_idx[1], 1);
    endtask

    task automatic inorder_after_ooo_wb();
        new_slots.delete();
        dispatch_entries(4);
        drive_writeback(1, new_slots[3], EXC_NONE, 0, EXC_NONE);
        drive_writeback(1, new_slots[1], EXC_NONE, 0, EXC_NONE);
        drive_writeback(1, new_slots[0], EXC_NONE, 0, EXC_NONE);
        drive_writeback(1, new_slots[2], EXC_NONE, 0, EXC_NONE);
        wait_drain();
    endtask

    task automatic oldest_blocks_commit();
        new_slots.delete();
        dispatch_entries(4);
        wb_q = new_slots[1:3];
        flush_writebacks();
        repeat (10) begin
            @(negedge clk);
            check_equal("commit_valid while oldest pending", commit_valid, 0);
        end
        drive_writeback(1, new_slots[0], EXC_NONE, 0, EXC_NONE);
        wait_drain();
    endtask

    task automatic full_buffer_stall();
        int oldest;
        new_slots.delete();
        for (int k = 0; k < `ROB_SIZE - 1; k++) begin
            check_equal("dispatch_ready before full", dispatch_ready, 1);
            dispatch_entries(1);
        end
        check_equal("dispatch_ready at 15 held", dispatch_ready, 0);
        // a held request must not be taken while ready is low
        dispatch_valid = '1;
        repeat (3) begin
            @(negedge clk);
            check_equal("dispatch_ready while held", dispatch_ready, 0);
            check_equal("dispatch_idx while held", dispatch_idx[0], exp_tail % `ROB_SIZE);
        end
        dispatch_valid = '0;
        oldest = new_slots.pop_front();
        drive_writeback(1, oldest, EXC_NONE, 0, EXC_NONE);
        wait_ready();
        wb_q = new_slots;
        flush_writebacks();
        wait_drain();
        check_equal("dispatch_idx after full", dispatch_idx[0], exp_tail % `ROB_SIZE);
    endtask

    task automatic precise_exception();
        new_slots.delete();
        dispatch_entries(3);
        drive_writeback(1, new_slots[1], EXC_LOAD_FAULT, 0, EXC_NONE);
        drive_writeback(2, new_slots[0], EXC_NONE, new_slots[2], EXC_NONE);
        wait_drain();
        exp_exc[new_slots[1]] = EXC_NONE;
        // two excepting neighbours retire one at a time
        new_slots.delete();
        dispatch_entries(2);
        drive_writeback(2, new_slots[0], EXC_ILLEGAL, new_slots[1], EXC_STORE_FAULT);
        wait_drain();
    endtask

    task automatic wraparound_stream();
        int r;
        int tmp;
        for (int chunk = 0; chunk < 6; chunk++) begin
            new_slots.delete();
            dispatch_entries(8);
            wb_q = new_slots;
            // shuffle the write-back order of this chunk
            for (int k = wb_q.size() - 1; k > 0; k--) begin
                r = int'(lcg_next() >> 8) % (k + 1);
                tmp = wb_q[k];
                wb_q[k] = wb_q[r];
                wb_q[r] = tmp;
            end
            flush_writebacks();
        end
        wait_drain();
    endtask

    initial begin
        rst              = 1'b1;
        dispatch_valid   = '0;
        dispatch_we      = '0;
        dispatch_vrd     = '0;
        dispatch_prd     = '0;
        dispatch_old_prd = '0;
        wb_valid         = '0;
        wb_idx           = '0;
        wb_exc           = '0;
        lcg_state        = 32'hdd6;
        exp_tail         = 0;
        for (int s = 0; s < `ROB_SIZE; s++) begin
            exp_exc[s] = EXC_NONE;
            wb_seen[s] = 1'b0;
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        reset_values();
        inorder_after_ooo_wb();
        oldest_blocks_commit();
        full_buffer_stall();
        precise_exception();
        wraparound_stream();

        $display("TB PASSED");
        $finish;
    end

endmodule

//--- rob_core.f
+incdir+include
hdl/rob_types_pkg.sv
hdl/rob_exc_pkg.sv
hdl/rob_read_if.sv
hdl/rob_slot_ram.sv
hdl/rob_payload_store.sv
hdl/rob_status_table.sv
hdl/rob_commit_ctrl.sv
hdl/rob_top.sv
test/tb_rob_top.sv

//--- run_sim.sh
#!/bin/sh
# build the reorder buffer testbench with Verilator, run it, scan the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary -Wno-fatal --top-module tb_rob_top -f rob_core.f \
    --Mdir "$BUILD_DIR" -o sim_rob > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    echo "build failed, see $BUILD_LOG"
    exit 1
fi

"./$BUILD_DIR/sim_rob" > "$SIM_LOG" 2>&1
sim_status=$?

if grep -q "TB FAILED" "$SIM_LOG"; then
    echo "simulation reported a failure, see $SIM_LOG"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status, see $SIM_LOG"
    exit 1
fi

echo "simulation finished cleanly"
exit 0
